/* bench/singleCpuTb.sv */
`timescale 1ns/1ps

module singleCpuTb;

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 16;
    localparam int randLen     = 40; // Random instructions before the halt
    localparam int numRandom   = 8;
    localparam int numPrograms = numRandom + 1; // Plus the directed program
    // Load, reset, execution and some slack per program
    localparam int watchdogNs  = numPrograms * (2 * (randLen + 1) + resetCycles + 10) * clkPeriod;

    typedef struct packed {
        logic [31:0] pcVal;
        logic [31:0] instVal;
        logic        wrEn;
        logic [4:0]  wrAddr;
        logic [31:0] wrData;
        logic        stEn;
        logic [31:0] stAddr;
        logic [31:0] stData;
    } traceT;

    logic        CLK;
    logic        RST;
    logic        progWrite;
    logic [7:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        regWriteEn;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;
    logic        storeEn;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    logic [31:0] prog [$];
    traceT       expTrace [$];
    logic [31:0] haltPc;
    logic [31:0] modelMem [64]; // Persists across programs like the DUT memory
    logic [15:0] lfsrState;
    string       testName;
    bit          checkGo;

    // Operation tables for the random generator
    logic [2:0] regOpF3 [6] = '{cpuPkg::f3AddSub, cpuPkg::f3AddSub, cpuPkg::f3And,
                                cpuPkg::f3Or, cpuPkg::f3Xor, cpuPkg::f3Slt};
    bit         regOpSub [6] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    logic [2:0] immOpF3 [5] = '{cpuPkg::f3AddSub, cpuPkg::f3And, cpuPkg::f3Or,
                                cpuPkg::f3Xor, cpuPkg::f3Slt};

    singleCpu i_dut (
        .CLK          (CLK),
        .RST          (RST),
        .progWrite    (progWrite),
        .progAddr     (progAddr),
        .progData     (progData),
        .pc           (pc),
        .inst         (inst),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .storeEn      (storeEn),
        .storeAddr    (storeAddr),
        .storeData    (storeData)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    // Instruction encoders
    function automatic logic [31:0] encR(logic sub, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, cpuPkg::opOp};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, cpuPkg::opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, cpuPkg::f3Word, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, cpuPkg::f3Beq, imm[4:1], imm[11], cpuPkg::opBranch};
    endfunction

    // 16 bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    // RV32I result of the arithmetic subset
    function automatic logic [31:0] arith(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // Instruction set model that fills expTrace for the program in prog
    function automatic void runModel();
        logic [31:0] xr [32];
        logic [31:0] curPc;
        logic [31:0] nextPc;
        logic [31:0] w;
        logic [31:0] immI;
        traceT       t;
        int          steps;
        expTrace.delete();
        foreach (xr[i]) xr[i] = '0;
        curPc = '0;
        steps = 0;
        while (prog[curPc >> 2] != encB(13'd0, 5'd0, 5'd0) && steps < 256) begin
            w = prog[curPc >> 2];
            immI = {{20{w[31]}}, w[31:20]};
            nextPc = curPc + 32'd4;
            t = '{curPc, w, 1'b0, w[11:7], 32'd0, 1'b0, 32'd0, xr[w[24:20]]};
            case (w[6:0])
                cpuPkg::opOp:    t.wrData = arith(w[14:12], w[30], xr[w[19:15]], xr[w[24:20]]);
                cpuPkg::opOpImm: t.wrData = arith(w[14:12], 1'b0, xr[w[19:15]], immI);
                cpuPkg::opLoad:  t.wrData = modelMem[(xr[w[19:15]] + immI) >> 2 & 32'h3F];
                cpuPkg::opStore: t.stAddr = xr[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
                default: begin
                    if (xr[w[19:15]] == xr[w[24:20]]) begin // beq taken
                        nextPc = curPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
            endcase
            t.wrEn = (w[6:0] == cpuPkg::opOp || w[6:0] == cpuPkg::opOpImm
                      || w[6:0] == cpuPkg::opLoad) && (t.wrAddr != 5'd0); // x0 never written
            t.stEn = (w[6:0] == cpuPkg::opStore);
            if (t.wrEn) xr[t.wrAddr] = t.wrData;
            if (t.stEn) modelMem[t.stAddr[7:2]] = t.stData;
            expTrace.push_back(t);
            curPc = nextPc;
            steps++;
        end
        haltPc = curPc;
    endfunction

    task automatic buildDirected();
        prog.delete();
        prog.push_back(encI(12'd5, 5'd0, cpuPkg::f3AddSub, 5'd1, cpuPkg::opOpImm));
        prog.push_back(encI(12'hFFD, 5'd0, cpuPkg::f3AddSub, 5'd2, cpuPkg::opOpImm)); // -3
        prog.push_back(encI(12'd7, 5'd1, cpuPkg::f3AddSub, 5'd3, cpuPkg::opOpImm));
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3AddSub, 5'd4));
        prog.push_back(encR(1'b1, 5'd1, 5'd2, cpuPkg::f3AddSub, 5'd5)); // sub
        prog.push_back(encR(1'b0, 5'd1, 5'd2, cpuPkg::f3Slt, 5'd6));    // -3 < 5
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3Slt, 5'd7));
        prog.push_back(encI(12'hFFF, 5'd2, cpuPkg::f3Slt, 5'd6, cpuPkg::opOpImm));
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3Xor, 5'd7));
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3Or, 5'd8));
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3And, 5'd9));
        prog.push_back(encI(12'h0F0, 5'd2, cpuPkg::f3And, 5'd10, cpuPkg::opOpImm));
        prog.push_back(encI(12'h800, 5'd1, cpuPkg::f3Or, 5'd11, cpuPkg::opOpImm));
        prog.push_back(encI(12'hFFF, 5'd2, cpuPkg::f3Xor, 5'd12, cpuPkg::opOpImm));
        prog.push_back(encI(12'd9, 5'd1, cpuPkg::f3AddSub, 5'd0, cpuPkg::opOpImm)); // x0
        prog.push_back(encR(1'b0, 5'd2, 5'd1, cpuPkg::f3AddSub, 5'd0));
        prog.push_back(encS(12'd8, 5'd3, 5'd0));
        prog.push_back(encS(12'd12, 5'd5, 5'd0));
        prog.push_back(encI(12'd8, 5'd0, cpuPkg::f3Word, 5'd13, cpuPkg::opLoad));
        prog.push_back(encI(12'd12, 5'd0, cpuPkg::f3Word, 5'd14, cpuPkg::opLoad));
        prog.push_back(encB(13'd8, 5'd1, 5'd1)); // Taken and skips the next one
        prog.push_back(encI(12'd99, 5'd0, cpuPkg::f3AddSub, 5'd15, cpuPkg::opOpImm));
        prog.push_back(encB(13'd8, 5'd2, 5'd1)); // Not taken
        prog.push_back(encI(12'd1, 5'd0, cpuPkg::f3AddSub, 5'd15, cpuPkg::opOpImm));
        prog.push_back(encS(12'd0, 5'd15, 5'd0));
        prog.push_back(encB(13'd0, 5'd0, 5'd0));
    endtask

    task automatic buildRandom();
        bit          stored [16];
        int          shadowEnd;
        int          kind;
        int          sel;
        int          k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [5:0]  raw;
        logic [11:0] imm;
        logic [11:0] off;
        logic [12:0] boff;
        prog.delete();
        foreach (stored[i]) stored[i] = 1'b0;
        shadowEnd = 0; // Stores before this index may be skipped by a beq
        for (int i = 0; i < randLen; i++) begin
            kind = takeBits(3);
            rd   = takeBits(3); // x0 to x7 only
            rs1  = takeBits(3);
            rs2  = takeBits(3);
            raw  = takeBits(6);
            imm  = {{6{raw[5]}}, raw};
            off  = takeBits(4) << 2;
            sel  = takeBits(3);
            case (kind)
                0, 1: prog.push_back(encR(regOpSub[sel % 6], rs2, rs1, regOpF3[sel % 6], rd));
                4: begin
                    prog.push_back(encS(off, rs2, 5'd0));
                    if (i >= shadowEnd) stored[off[5:2]] = 1'b1;
                end
                5: begin
                    if (stored[off[5:2]]) begin
                        prog.push_back(encI(off, 5'd0, cpuPkg::f3Word, rd, cpuPkg::opLoad));
                    end else begin
                        prog.push_back(encI(imm, rs1, cpuPkg::f3AddSub, rd, cpuPkg::opOpImm));
                    end
                end
                6: begin
                    k = (sel % 4) + 1;
                    if (i + k > randLen) k = randLen - i; // Land on the halt at most
                    boff = k * 4;
                    prog.push_back(encB(boff, rs2, rs1));
                    if (i + k > shadowEnd) shadowEnd = i + k;
                end
                default: prog.push_back(encI(imm, rs1, immOpF3[sel % 5], rd, cpuPkg::opOpImm));
            endcase
        end
        prog.push_back(encB(13'd0, 5'd0, 5'd0));
    endtask

    function automatic string failLine(string what, logic [31:0] expected, logic [31:0] actual);
        return $sformatf("Fail %s %s expected %h actual %h", testName, what, expected, actual);
    endfunction

    task automatic stopOnError(string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Load under reset and release so the checker follows the run
    task automatic runProgram(string name);
        testName = name;
        runModel();
        @(negedge CLK);
        RST = 1'b1;
        foreach (prog[i]) begin
            progWrite = 1'b1;
            progAddr  = i[7:0];
            progData  = prog[i];
            @(negedge CLK);
        end
        progWrite = 1'b0;
        repeat (resetCycles) @(negedge CLK);
        RST = 1'b0;
        checkGo = 1'b1;
        wait (!checkGo);
    endtask

    // Trace checker with one expected event per rising edge
    always begin
        traceT t;
        wait (checkGo);
        foreach (expTrace[n]) begin
            t = expTrace[n];
            @(posedge CLK);
            assert (pc == t.pcVal) else stopOnError(failLine("pc", t.pcVal, pc));
            assert (inst == t.instVal) else stopOnError(failLine("inst", t.instVal, inst));
            assert (regWriteEn == t.wrEn)
                else stopOnError(failLine("regWriteEn", t.wrEn, regWriteEn));
            if (t.wrEn) begin
                assert (regWriteAddr == t.wrAddr)
                    else stopOnError(failLine("regWriteAddr", t.wrAddr, regWriteAddr));
                assert (regWriteData == t.wrData)
                    else stopOnError(failLine("regWriteData", t.wrData, regWriteData));
            end
            assert (storeEn == t.stEn) else stopOnError(failLine("storeEn", t.stEn, storeEn));
            if (t.stEn) begin
                assert (storeAddr == t.stAddr)
                    else stopOnError(failLine("storeAddr", t.stAddr, storeAddr));
                assert (storeData == t.stData)
                    else stopOnError(failLine("storeData", t.stData, storeData));
            end
        end
        repeat (2) begin // Core must sit still on the halt
            @(posedge CLK);
            assert (pc == haltPc) else stopOnError(failLine("halt pc", haltPc, pc));
            assert (!regWriteEn && !storeEn)
                else stopOnError($sformatf("Trace strobe active at the halt in %s", testName));
        end
        checkGo = 1'b0;
    end

    always @(posedge CLK) begin
        if (RST) begin
            assert (!regWriteEn && !storeEn)
                else stopOnError("Trace strobe went active while reset was held");
        end
    end

    initial begin
        #(watchdogNs * 1ns);
        stopOnError("Watchdog expired, the core never reached its halt");
    end

    initial begin
        CLK       = 1'b0;
        RST       = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        checkGo   = 1'b0;
        lfsrState = 16'd25125;
        buildDirected();
        runProgram("directed");
        for (int p = 1; p <= numRandom; p++) begin
            buildRandom();
            runProgram($sformatf("random%0d", p));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::xlen-1:0]   operandA,
    input  logic [cpuPkg::xlen-1:0]   operandB,
    input  cpuPkg::aluOpT             aluOp,
    output logic [cpuPkg::xlen-1:0]   result,
    output logic                      zero
);

    logic signed [cpuPkg::xlen-1:0] signedA;
    logic signed [cpuPkg::xlen-1:0] signedB;
    logic                           lessThan;

    assign signedA  = operandA;
    assign signedB  = operandB;
    assign lessThan = (signedA < signedB); // Two's complement compare for slt

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: result = operandA + operandB;
            cpuPkg::aluSub: result = operandA - operandB;
            cpuPkg::aluAnd: result = operandA & operandB;
            cpuPkg::aluOr:  result = operandA | operandB;
            cpuPkg::aluXor: result = operandA ^ operandB;
            cpuPkg::aluSlt: result = {{(cpuPkg::xlen-1){1'b0}}, lessThan};
            default:        result = '0;
        endcase
    end

    // Used by beq together with aluSub
    assign zero = (result == '0);

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    // Datapath and register file geometry
    localparam int xlen         = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 1 << regAddrWidth;

    // Memory sizes in words
    localparam int instMemDepth   = 256;
    localparam int dataMemDepth   = 64;
    localparam int instIndexWidth = $clog2(instMemDepth); // 8 bit PC index
    localparam int dataIndexWidth = $clog2(dataMemDepth); // 6 bit data index

    // Byte increment of the PC per instruction
    localparam logic [xlen-1:0] pcStep = 32'd4;

    // funct3 codes of the supported subset
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010; // lw and sw
    localparam logic [2:0] f3Beq    = 3'b000;

    // Major opcode field, inst[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opBranch = 7'b1100011
    } opcodeT;

    // Operations the ALU can carry out
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOpT;

endpackage

/* hdl/dataMem.sv */
`timescale 1ns/1ps

module dataMem (
    input  logic                      CLK,
    input  logic                      writeEn,
    input  logic [cpuPkg::xlen-1:0]   addr,
    input  logic [cpuPkg::xlen-1:0]   writeData,
    output logic [cpuPkg::xlen-1:0]   readData
);

    logic [cpuPkg::xlen-1:0] mem [cpuPkg::dataMemDepth];

    logic [cpuPkg::dataIndexWidth-1:0] wordIndex;

    // Word aligned, upper address bits ignored so the space wraps
    assign wordIndex = addr[cpuPkg::dataIndexWidth+1:2];

    // Combinational read for lw in the same cycle
    assign readData = mem[wordIndex];

    always_ff @(posedge CLK) begin
        if (writeEn) begin
            mem[wordIndex] <= writeData;
        end
    end

endmodule

/* hdl/instDecode.sv */
`timescale 1ns/1ps

module instDecode (
    input  logic [cpuPkg::xlen-1:0]   inst,
    output logic                      regWrite,
    output logic                      memWrite,
    output logic                      memToReg,
    output logic                      aluSrc,
    output logic                      branch,
    output cpuPkg::aluOpT             aluOp,
    output logic [cpuPkg::xlen-1:0]   imm
);

    cpuPkg::opcodeT  opcode;
    cpuPkg::aluOpT   arithOp;
    logic [2:0]      funct3;
    logic            isRegReg;
    logic            arithOk;
    logic [cpuPkg::xlen-1:0] immI;
    logic [cpuPkg::xlen-1:0] immS;
    logic [cpuPkg::xlen-1:0] immB;

    assign opcode   = cpuPkg::opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign isRegReg = (opcode == cpuPkg::opOp);

    // Sign extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    // B format, already shifted left by one
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // ALU control from funct3, bit 30 picks sub for register-register only
    always_comb begin
        arithOp = cpuPkg::aluAdd;
        arithOk = 1'b1;
        case (funct3)
            cpuPkg::f3AddSub: arithOp = (isRegReg && inst[30]) ? cpuPkg::aluSub : cpuPkg::aluAdd;
            cpuPkg::f3Slt:    arithOp = cpuPkg::aluSlt;
            cpuPkg::f3Xor:    arithOp = cpuPkg::aluXor;
            cpuPkg::f3Or:     arithOp = cpuPkg::aluOr;
            cpuPkg::f3And:    arithOp = cpuPkg::aluAnd;
            default:          arithOk = 1'b0; // Shifts and sltu are not built
        endcase
    end

    // Main control
    always_comb begin
        regWrite = 1'b0; // Defaults make any other opcode a no-op
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        aluOp    = cpuPkg::aluAdd;
        imm      = '0;
        case (opcode)
            cpuPkg::opLoad: begin
                if (funct3 == cpuPkg::f3Word) begin
                    regWrite = 1'b1;
                    memToReg = 1'b1;
                    aluSrc   = 1'b1;
                end
                imm = immI;
            end
            cpuPkg::opStore: begin
                memWrite = (funct3 == cpuPkg::f3Word);
                aluSrc   = 1'b1;
                imm      = immS;
            end
            cpuPkg::opOp: begin
                regWrite = arithOk;
                aluOp    = arithOp;
            end
            cpuPkg::opOpImm: begin
                regWrite = arithOk;
                aluSrc   = 1'b1;
                aluOp    = arithOp;
                imm      = immI;
            end
            cpuPkg::opBranch: begin
                branch = (funct3 == cpuPkg::f3Beq);
                aluOp  = cpuPkg::aluSub; // Equal operands give a zero difference
                imm    = immB;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/instFetch.sv */
`timescale 1ns/1ps

module instFetch (
    input  logic                                CLK,
    input  logic                                RST,
    input  logic                                progWrite,
    input  logic [cpuPkg::instIndexWidth-1:0]   progAddr,
    input  logic [cpuPkg::xlen-1:0]             progData,
    input  logic                                branch,
    input  logic                                zero,
    input  logic [cpuPkg::xlen-1:0]             imm,
    output logic [cpuPkg::xlen-1:0]             pc,
    output logic [cpuPkg::xlen-1:0]             inst
);

    // Instruction store, one word per entry
    logic [cpuPkg::xlen-1:0] instMem [cpuPkg::instMemDepth];

    logic                                takeBranch;
    logic [cpuPkg::xlen-1:0]             nextPc;
    logic [cpuPkg::instIndexWidth-1:0]   pcIndex;

    // Word index from the byte address
    assign pcIndex = pc[cpuPkg::instIndexWidth+1:2];

    // Fetch is combinational from the current PC
    assign inst = instMem[pcIndex];

    // beq is taken only when the ALU found equal operands
    assign takeBranch = branch & zero;

    always_comb begin
        if (takeBranch) begin
            nextPc = pc + imm; // B immediate already carries the low zero bit
        end else begin
            nextPc = pc + cpuPkg::pcStep;
        end
    end

    // Program counter
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0; // First instruction sits at address 0
        end else begin
            pc <= nextPc;
        end
    end

    // Program load port, used by the testbench while reset is held
    always_ff @(posedge CLK) begin
        if (progWrite) begin
            instMem[progAddr] <= progData;
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic [cpuPkg::regAddrWidth-1:0]   readAddr1,
    input  logic [cpuPkg::regAddrWidth-1:0]   readAddr2,
    input  logic                              writeEn,
    input  logic [cpuPkg::regAddrWidth-1:0]   writeAddr,
    input  logic [cpuPkg::xlen-1:0]           writeData,
    output logic [cpuPkg::xlen-1:0]           readData1,
    output logic [cpuPkg::xlen-1:0]           readData2
);

    logic [cpuPkg::xlen-1:0] regs [cpuPkg::numRegs];

    logic writeOk;

    // x0 is hardwired, so writes to it are dropped
    assign writeOk = writeEn && (writeAddr != '0);

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeOk) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Two asynchronous read ports
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

/* hdl/singleCpu.sv */
`timescale 1ns/1ps

module singleCpu (
    input  logic                                CLK,
    input  logic                                RST,
    input  logic                                progWrite,
    input  logic [cpuPkg::instIndexWidth-1:0]   progAddr,
    input  logic [cpuPkg::xlen-1:0]             progData,
    output logic [cpuPkg::xlen-1:0]             pc,
    output logic [cpuPkg::xlen-1:0]             inst,
    output logic                                regWriteEn,
    output logic [cpuPkg::regAddrWidth-1:0]     regWriteAddr,
    output logic [cpuPkg::xlen-1:0]             regWriteData,
    output logic                                storeEn,
    output logic [cpuPkg::xlen-1:0]             storeAddr,
    output logic [cpuPkg::xlen-1:0]             storeData
);

    // Control levels from decode
    logic           regWrite;
    logic           memWrite;
    logic           memToReg;
    logic           aluSrc;
    logic           branch;
    cpuPkg::aluOpT  aluOp;

    logic [cpuPkg::xlen-1:0]          imm;
    logic [cpuPkg::xlen-1:0]          readData1;
    logic [cpuPkg::xlen-1:0]          readData2;
    logic [cpuPkg::xlen-1:0]          operandB;
    logic [cpuPkg::xlen-1:0]          aluResult;
    logic                             zero;
    logic [cpuPkg::xlen-1:0]          memReadData;
    logic [cpuPkg::xlen-1:0]          wbData;
    logic [cpuPkg::regAddrWidth-1:0]  rs1;
    logic [cpuPkg::regAddrWidth-1:0]  rs2;
    logic [cpuPkg::regAddrWidth-1:0]  rd;

    // Register fields of the current instruction
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    instFetch uFetch (
        .CLK       (CLK),
        .RST       (RST),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .branch    (branch),
        .zero      (zero),
        .imm       (imm),
        .pc        (pc),
        .inst      (inst)
    );

    regFile uRegs (
        .CLK       (CLK),
        .RST       (RST),
        .readAddr1 (rs1),
        .readAddr2 (rs2),
        .writeEn   (regWriteEn),
        .writeAddr (rd),
        .writeData (wbData),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    instDecode uDecode (
        .inst     (inst),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .aluSrc   (aluSrc),
        .branch   (branch),
        .aluOp    (aluOp),
        .imm      (imm)
    );

    assign operandB = aluSrc ? imm : readData2; // Immediate or rs2

    alu uAlu (
        .operandA (readData1),
        .operandB (operandB),
        .aluOp    (aluOp),
        .result   (aluResult),
        .zero     (zero)
    );

    dataMem uDataMem (
        .CLK       (CLK),
        .writeEn   (storeEn),
        .addr      (aluResult),
        .writeData (readData2),
        .readData  (memReadData)
    );

    // Writeback select, load data or ALU result
    assign wbData = memToReg ? memReadData : aluResult;

    // Trace of the instruction at pc, held quiet while in reset
    assign regWriteEn   = !RST && regWrite && (rd != '0);
    assign regWriteAddr = rd;
    assign regWriteData = wbData;
    assign storeEn      = !RST && memWrite;
    assign storeAddr    = aluResult;
    assign storeData    = readData2;

endmodule

/* project.f */
hdl/cpuPkg.sv
hdl/instFetch.sv
hdl/regFile.sv
hdl/instDecode.sv
hdl/alu.sv
hdl/dataMem.sv
hdl/singleCpu.sv
bench/singleCpuTb.sv
